/* source/isaPkg.sv */
`default_nettype none

package isaPkg;

	localparam int wordWidth = 32;
	localparam int opcodeWidth = 5;
	localparam int opcodeLsb = 27; // opcode sits in ir[31:27]
	localparam int aluOpWidth = 5;

	// opcode field values
	localparam logic [opcodeWidth-1:0] opLd = 5'd0;
	localparam logic [opcodeWidth-1:0] opLdi = 5'd1;
	localparam logic [opcodeWidth-1:0] opSt = 5'd2;
	localparam logic [opcodeWidth-1:0] opAdd = 5'd3;
	localparam logic [opcodeWidth-1:0] opSub = 5'd4;
	localparam logic [opcodeWidth-1:0] opAnd = 5'd5;
	localparam logic [opcodeWidth-1:0] opOr = 5'd6;
	localparam logic [opcodeWidth-1:0] opShr = 5'd7;
	localparam logic [opcodeWidth-1:0] opShra = 5'd8;
	localparam logic [opcodeWidth-1:0] opShl = 5'd9;
	localparam logic [opcodeWidth-1:0] opRor = 5'd10;
	localparam logic [opcodeWidth-1:0] opRol = 5'd11;
	localparam logic [opcodeWidth-1:0] opAddi = 5'd12;
	localparam logic [opcodeWidth-1:0] opAndi = 5'd13;
	localparam logic [opcodeWidth-1:0] opOri = 5'd14;
	localparam logic [opcodeWidth-1:0] opNeg = 5'd17;
	localparam logic [opcodeWidth-1:0] opNot = 5'd18;
	localparam logic [opcodeWidth-1:0] opBr = 5'd19;
	localparam logic [opcodeWidth-1:0] opNop = 5'd26;
	localparam logic [opcodeWidth-1:0] opHalt = 5'd27;

	// ALU function codes
	localparam logic [aluOpWidth-1:0] aluAdd = 5'd1;
	localparam logic [aluOpWidth-1:0] aluSub = 5'd2;
	localparam logic [aluOpWidth-1:0] aluAnd = 5'd3;
	localparam logic [aluOpWidth-1:0] aluOr = 5'd4;
	localparam logic [aluOpWidth-1:0] aluNeg = 5'd5;
	localparam logic [aluOpWidth-1:0] aluNot = 5'd6;
	localparam logic [aluOpWidth-1:0] aluShr = 5'd7;
	localparam logic [aluOpWidth-1:0] aluShl = 5'd8;
	localparam logic [aluOpWidth-1:0] aluRor = 5'd9;
	localparam logic [aluOpWidth-1:0] aluRol = 5'd10;
	localparam logic [aluOpWidth-1:0] aluShra = 5'd13;
	localparam logic [aluOpWidth-1:0] aluIncPc = 5'd14;
	localparam logic [aluOpWidth-1:0] aluBranchAdd = 5'd15;

	typedef enum logic [3:0] {
		regAlu, immAlu, unaryAlu, load, loadImm, store, branch, nop, halt
	} instrClass;

	typedef enum logic [3:0] {
		resetStep, fetch0, fetch1, fetch2, exec0, exec1, exec2, exec3, exec4, halted
	} stepType;

	// execution cycles per class
	localparam logic [2:0] aluSteps = 3'd3; // regAlu, immAlu, loadImm
	localparam logic [2:0] unarySteps = 3'd2;
	localparam logic [2:0] loadSteps = 3'd5;
	localparam logic [2:0] storeSteps = 3'd4;
	localparam logic [2:0] branchSteps = 3'd4;
	localparam logic [2:0] nopSteps = 3'd1;

	function automatic logic [2:0] execSteps(instrClass cls);
		case (cls)
			regAlu, immAlu, loadImm: return aluSteps;
			unaryAlu: return unarySteps;
			load: return loadSteps;
			store: return storeSteps;
			branch: return branchSteps;
			default: return nopSteps; // halt never reaches execution
		endcase
	endfunction

endpackage

`default_nettype wire

/* source/datapathPkg.sv */
`default_nettype none

package datapathPkg;

	localparam int ctrlWidth = 32;

	// register load enables, bit index into enable
	localparam int zIn = 18;
	localparam int yIn = 19;
	localparam int pcIn = 20;
	localparam int mdrIn = 21;
	localparam int irIn = 24;
	localparam int marIn = 25;
	localparam int conIn = 27; // branch condition flip-flop

	// bus drivers, bit index into busSelect
	localparam int zLowOut = 19;
	localparam int pcOut = 20;
	localparam int mdrOut = 21;
	localparam int cOut = 23; // sign-extended immediate from ir

endpackage

`default_nettype wire

/* source/opcodeDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module opcodeDecoder (
	input wire logic [isaPkg::wordWidth-1:0] ir,
	output isaPkg::instrClass decodedClass,
	output logic [isaPkg::aluOpWidth-1:0] decodedAluOp
);
	import isaPkg::*;

	logic [opcodeWidth-1:0] opcode;

	assign opcode = ir[opcodeLsb +: opcodeWidth];

	always_comb begin
		decodedClass = nop; // unknown opcodes fall through as nop
		decodedAluOp = '0;
		case (opcode)
			// three-operand register forms
			opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol: begin
				decodedClass = regAlu;
				case (opcode)
					opAdd: decodedAluOp = aluAdd;
					opSub: decodedAluOp = aluSub;
					opAnd: decodedAluOp = aluAnd;
					opOr: decodedAluOp = aluOr;
					opShr: decodedAluOp = aluShr;
					opShra: decodedAluOp = aluShra;
					opShl: decodedAluOp = aluShl;
					opRor: decodedAluOp = aluRor;
					default: decodedAluOp = aluRol;
				endcase
			end
			opAddi: begin
				decodedClass = immAlu;
				decodedAluOp = aluAdd;
			end
			opAndi: begin
				decodedClass = immAlu;
				decodedAluOp = aluAnd;
			end
			opOri: begin
				decodedClass = immAlu;
				decodedAluOp = aluOr;
			end
			opNeg: begin
				decodedClass = unaryAlu;
				decodedAluOp = aluNeg;
			end
			opNot: begin
				decodedClass = unaryAlu;
				decodedAluOp = aluNot;
			end
			// memory forms compute base plus offset
			opLd: begin
				decodedClass = load;
				decodedAluOp = aluAdd;
			end
			opLdi: begin
				decodedClass = loadImm;
				decodedAluOp = aluAdd;
			end
			opSt: begin
				decodedClass = store;
				decodedAluOp = aluAdd;
			end
			opBr: begin
				decodedClass = branch;
				decodedAluOp = aluAdd; // pc plus offset
			end
			opHalt: decodedClass = halt;
			opNop: decodedClass = nop;
			default: decodedClass = nop;
		endcase
	end

endmodule

`default_nettype wire

/* source/stepSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module stepSequencer (
	input wire logic clk,
	input wire logic Reset,
	input wire logic Stop,
	input wire isaPkg::instrClass decodedClass,
	input wire logic [isaPkg::aluOpWidth-1:0] decodedAluOp,
	output isaPkg::stepType step,
	output isaPkg::instrClass instrClass,
	output logic [isaPkg::aluOpWidth-1:0] aluOp,
	output logic run
);
	import isaPkg::*;

	stepType nextStep;
	logic [2:0] execIndex; // position inside the execution phase
	logic [2:0] lastIndex;

	assign lastIndex = execSteps(instrClass) - 3'd1;

	always_comb begin
		case (step)
			exec1: execIndex = 3'd1;
			exec2: execIndex = 3'd2;
			exec3: execIndex = 3'd3;
			exec4: execIndex = 3'd4;
			default: execIndex = 3'd0;
		endcase
	end

	always_comb begin
		nextStep = step;
		case (step)
			resetStep: nextStep = fetch0;
			fetch0: nextStep = fetch1;
			fetch1: nextStep = fetch2;
			fetch2: begin
				if (decodedClass == halt)
					nextStep = halted;
				else
					nextStep = exec0;
			end
			exec0, exec1, exec2, exec3, exec4: begin
				if (execIndex == lastIndex)
					nextStep = fetch0; // instruction done
				else
					nextStep = stepType'(step + 4'd1);
			end
			halted: nextStep = halted; // only Reset leaves
			default: nextStep = resetStep;
		endcase
		// Stop wins over everything on the edge it is seen
		if (Stop)
			nextStep = halted;
	end

	always_ff @(posedge clk or posedge Reset) begin
		if (Reset) begin
			step <= resetStep;
			instrClass <= nop;
			aluOp <= '0;
		end else begin
			step <= nextStep;
			if (step == fetch2) begin // ir is stable until this edge
				instrClass <= decodedClass;
				aluOp <= decodedAluOp;
			end
		end
	end

	assign run = (step != halted);

endmodule

`default_nettype wire

/* source/controlWordGen.sv */
`timescale 1ns/10ps
`default_nettype none

module controlWordGen (
	input wire isaPkg::stepType step,
	input wire isaPkg::instrClass instrClass,
	input wire logic [isaPkg::aluOpWidth-1:0] aluOp,
	input wire logic CONFFOut,
	output logic [datapathPkg::ctrlWidth-1:0] enable,
	output logic [datapathPkg::ctrlWidth-1:0] busSelect,
	output logic [isaPkg::aluOpWidth-1:0] aluControl,
	output logic mdRead,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic rin,
	output logic rout,
	output logic baOut,
	output logic readRam,
	output logic writeRam
);
	import isaPkg::*;
	import datapathPkg::*;

	always_comb begin
		enable = '0;
		busSelect = '0;
		aluControl = '0;
		mdRead = 1'b0;
		gra = 1'b0;
		grb = 1'b0;
		grc = 1'b0;
		rin = 1'b0;
		rout = 1'b0;
		baOut = 1'b0;
		readRam = 1'b0;
		writeRam = 1'b0;
		case (step)
			fetch0: begin // MAR <= PC, Z <= PC + 1
				busSelect[pcOut] = 1'b1;
				enable[marIn] = 1'b1;
				enable[zIn] = 1'b1;
				aluControl = aluIncPc;
			end
			fetch1: begin
				busSelect[zLowOut] = 1'b1;
				enable[pcIn] = 1'b1;
				enable[mdrIn] = 1'b1;
				mdRead = 1'b1;
				readRam = 1'b1;
			end
			fetch2: begin
				busSelect[mdrOut] = 1'b1;
				enable[irIn] = 1'b1;
			end
			exec0: begin
				case (instrClass)
					regAlu, immAlu: begin
						grb = 1'b1;
						rout = 1'b1;
						enable[yIn] = 1'b1;
					end
					loadImm, load, store: begin // base register, r0 reads as zero
						grb = 1'b1;
						baOut = 1'b1;
						enable[yIn] = 1'b1;
					end
					unaryAlu: begin
						grb = 1'b1;
						rout = 1'b1;
						enable[zIn] = 1'b1;
						aluControl = aluOp;
					end
					branch: begin
						gra = 1'b1;
						rout = 1'b1;
						enable[conIn] = 1'b1; // evaluate condition on Ra
					end
					default: ;
				endcase
			end
			exec1: begin
				case (instrClass)
					regAlu: begin
						grc = 1'b1;
						rout = 1'b1;
						enable[zIn] = 1'b1;
						aluControl = aluOp;
					end
					immAlu, loadImm, load, store: begin
						busSelect[cOut] = 1'b1;
						enable[zIn] = 1'b1;
						aluControl = aluOp;
					end
					unaryAlu: begin
						busSelect[zLowOut] = 1'b1;
						gra = 1'b1;
						rin = 1'b1;
					end
					branch: begin
						busSelect[pcOut] = 1'b1;
						enable[yIn] = 1'b1;
					end
					default: ;
				endcase
			end
			exec2: begin
				case (instrClass)
					regAlu, immAlu, loadImm: begin // write back result
						busSelect[zLowOut] = 1'b1;
						gra = 1'b1;
						rin = 1'b1;
					end
					load, store: begin
						busSelect[zLowOut] = 1'b1;
						enable[marIn] = 1'b1;
					end
					branch: begin
						busSelect[cOut] = 1'b1;
						enable[zIn] = 1'b1;
						aluControl = aluBranchAdd;
					end
					default: ;
				endcase
			end
			exec3: begin
				case (instrClass)
					load: begin
						mdRead = 1'b1;
						readRam = 1'b1;
						enable[mdrIn] = 1'b1;
					end
					store: begin
						gra = 1'b1;
						baOut = 1'b1;
						rout = 1'b1;
						writeRam = 1'b1;
					end
					branch: begin
						busSelect[zLowOut] = CONFFOut; // taken only
						enable[pcIn] = CONFFOut;
					end
					default: ;
				endcase
			end
			exec4: begin
				if (instrClass == load) begin
					busSelect[mdrOut] = 1'b1;
					gra = 1'b1;
					rin = 1'b1;
				end
			end
			default: ; // resetStep and halted drive nothing
		endcase
	end

endmodule

`default_nettype wire

/* source/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
	input wire logic clk,
	input wire logic Reset,
	input wire logic Stop,
	input wire logic CONFFOut,
	input wire logic [isaPkg::wordWidth-1:0] ir,
	output logic run,
	output logic [datapathPkg::ctrlWidth-1:0] enable,
	output logic [datapathPkg::ctrlWidth-1:0] busSelect,
	output logic [isaPkg::aluOpWidth-1:0] aluControl,
	output logic mdRead,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic rin,
	output logic rout,
	output logic baOut,
	output logic readRam,
	output logic writeRam
);
	import isaPkg::*;

	instrClass decodedClass; // straight from ir
	logic [aluOpWidth-1:0] decodedAluOp;
	stepType step;
	instrClass currentClass; // held for the execution phase
	logic [aluOpWidth-1:0] currentAluOp;

	opcodeDecoder opcodeDecoder_i (
		.ir(ir),
		.decodedClass(decodedClass),
		.decodedAluOp(decodedAluOp)
	);

	stepSequencer stepSequencer_i (
		.clk(clk),
		.Reset(Reset),
		.Stop(Stop),
		.decodedClass(decodedClass),
		.decodedAluOp(decodedAluOp),
		.step(step),
		.instrClass(currentClass),
		.aluOp(currentAluOp),
		.run(run)
	);

	controlWordGen controlWordGen_i (
		.step(step),
		.instrClass(currentClass),
		.aluOp(currentAluOp),
		.CONFFOut(CONFFOut),
		.enable(enable),
		.busSelect(busSelect),
		.aluControl(aluControl),
		.mdRead(mdRead),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rin(rin),
		.rout(rout),
		.baOut(baOut),
		.readRam(readRam),
		.writeRam(writeRam)
	);

endmodule

`default_nettype wire

/* testbench/controlUnit_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit_properties (
	input wire logic clk,
	input wire logic Reset,
	input wire logic Stop,
	input wire logic CONFFOut,
	input wire logic [isaPkg::wordWidth-1:0] ir,
	input wire logic run,
	input wire logic [datapathPkg::ctrlWidth-1:0] enable,
	input wire logic [datapathPkg::ctrlWidth-1:0] busSelect,
	input wire logic [isaPkg::aluOpWidth-1:0] aluControl,
	input wire logic mdRead, gra, grb, grc, rin, rout, baOut, readRam, writeRam
);
	import isaPkg::*;
	import datapathPkg::*;

	int unsigned failCount = 0; // read by the testbench
	logic [8:0] strobes;
	logic quiet;
	logic isFetch0;
	logic isFetch1;
	logic isFetch2;
	logic [opcodeWidth-1:0] irOp;
	logic [opcodeWidth-1:0] lastOp; // opcode of the instruction in execution

	function automatic logic [ctrlWidth-1:0] bitAt(int pos);
		return ctrlWidth'(1) << pos;
	endfunction

	// ALU code from the instruction table, 0 for opcodes outside the ALU classes
	function automatic logic [aluOpWidth-1:0] expectedAlu(logic [opcodeWidth-1:0] op);
		case (op)
			opAdd, opAddi: return aluAdd;
			opSub: return aluSub;
			opAnd, opAndi: return aluAnd;
			opOr, opOri: return aluOr;
			opShr: return aluShr;
			opShra: return aluShra;
			opShl: return aluShl;
			opRor: return aluRor;
			opRol: return aluRol;
			opNeg: return aluNeg;
			opNot: return aluNot;
			default: return '0;
		endcase
	endfunction

	assign strobes = {mdRead, gra, grb, grc, rin, rout, baOut, readRam, writeRam};
	assign irOp = ir[opcodeLsb +: opcodeWidth];
	assign quiet = enable == '0 && busSelect == '0 && aluControl == '0 && strobes == '0;
	assign isFetch0 = busSelect == bitAt(pcOut) && enable == (bitAt(marIn) | bitAt(zIn))
		&& aluControl == aluIncPc && strobes == '0;
	assign isFetch1 = busSelect == bitAt(zLowOut) && enable == (bitAt(pcIn) | bitAt(mdrIn))
		&& aluControl == '0 && strobes == 9'b1_0000_0010; // mdRead and readRam
	assign isFetch2 = busSelect == bitAt(mdrOut) && enable == bitAt(irIn)
		&& aluControl == '0 && strobes == '0;

	always_ff @(posedge clk or posedge Reset) begin
		if (Reset)
			lastOp <= opNop;
		else if (isFetch2)
			lastOp <= irOp;
	end

	resetIdle: assert property (@(posedge clk) Reset |-> (run && quiet))
		else begin
			$error("a control was active or run was low during Reset");
			failCount++;
		end

	resetRelease: assert property (@(posedge clk) $fell(Reset) |-> (run && quiet) ##1 isFetch0)
		else begin
			$error("the cycle after Reset was not idle or was not followed by fetch0");
			failCount++;
		end

	fetchOrder: assert property (@(posedge clk) disable iff (Reset || Stop)
		isFetch0 |=> isFetch1 ##1 isFetch2)
		else begin
			$error("fetch0 was not followed by fetch1 and fetch2");
			failCount++;
		end

	aluCode: assert property (@(posedge clk) disable iff (Reset || Stop)
		(enable[zIn] && !isFetch0 && expectedAlu(lastOp) != '0)
		|-> aluControl == expectedAlu(lastOp))
		else begin
			$error("Mismatch aluCode: expected %0d, actual %0d",
				expectedAlu($sampled(lastOp)), $sampled(aluControl));
			failCount++;
		end

	aluWriteBack: assert property (@(posedge clk) disable iff (Reset || Stop)
		(enable[zIn] && !isFetch0 && expectedAlu(lastOp) != '0)
		|=> (busSelect[zLowOut] && gra && rin) ##1 isFetch0)
		else begin
			$error("ALU result was not written back before the next fetch");
			failCount++;
		end

	loadAccess: assert property (@(posedge clk) disable iff (Reset || Stop)
		(enable[marIn] && !isFetch0 && lastOp == opLd)
		|=> (readRam && mdRead && enable[mdrIn]) ##1 (busSelect[mdrOut] && gra && rin))
		else begin
			$error("ld did not read memory after its address step");
			failCount++;
		end

	storeAccess: assert property (@(posedge clk) disable iff (Reset || Stop)
		(enable[marIn] && !isFetch0 && lastOp == opSt)
		|=> (writeRam && gra && baOut && rout))
		else begin
			$error("st did not write memory after its address step");
			failCount++;
		end

	ldiWrite: assert property (@(posedge clk) disable iff (Reset || Stop)
		(isFetch2 && irOp == opLdi) |-> ##3 (busSelect[zLowOut] && gra && rin))
		else begin
			$error("ldi did not write its register in the third execution cycle");
			failCount++;
		end

	branchTaken: assert property (@(posedge clk) disable iff (Reset || Stop)
		(enable[zIn] && aluControl == aluBranchAdd) |=> enable[pcIn] == CONFFOut)
		else begin
			$error("Mismatch branchTaken: expected pcIn %0b, actual %0b",
				$sampled(CONFFOut), $sampled(enable[pcIn]));
			failCount++;
		end

	haltStops: assert property (@(posedge clk) disable iff (Reset)
		(isFetch2 && irOp == opHalt) |=> !run)
		else begin
			$error("run stayed high after halt");
			failCount++;
		end

	stopStops: assert property (@(posedge clk) disable iff (Reset) Stop |=> !run)
		else begin
			$error("run stayed high after Stop");
			failCount++;
		end

	haltedIdle: assert property (@(posedge clk) disable iff (Reset)
		!run |-> quiet ##1 !run)
		else begin
			$error("the halted state drove a control or was left without Reset");
			failCount++;
		end

endmodule

bind controlUnit controlUnit_properties controlUnit_properties_i (.*);

`default_nettype wire

/* testbench/controlUnit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit_tb;
	import isaPkg::*;
	import datapathPkg::*;

	logic clk = 1'b0;
	logic Reset;
	logic Stop;
	logic CONFFOut = 1'b0;
	logic [wordWidth-1:0] ir = '0;
	logic run, mdRead, gra, grb, grc, rin, rout, baOut, readRam, writeRam;
	logic [ctrlWidth-1:0] enable;
	logic [ctrlWidth-1:0] busSelect;
	logic [aluOpWidth-1:0] aluControl;

	integer seed = 38;
	int cycles = 0;
	int cycleLimit = 50 * 8 + 50; // 50 instructions of at most 8 cycles, plus margin
	logic [opcodeWidth-1:0] nextOp;
	logic [31:0] coin;

	// first run up to halt, then the run that Stop cuts short
	logic [opcodeWidth-1:0] pending[$] = '{
		opLd, opLdi, opSt, opAdd, opBr, opSub, opAnd, opOr, opBr, opShr, opShra, opShl,
		opBr, opRor, opRol, opAddi, opBr, opAndi, opOri, opNeg, opBr, opNot, opNop,
		5'd30, opBr, opHalt,
		opAdd, opLd, opBr, opSt
	};

	controlUnit controlUnit_i (.*);

	always #50 clk = ~clk;

	task automatic abortRun(input string why);
		$display("SIMULATION FAILED");
		$fatal(1, "%s", why);
	endtask

	function automatic logic [wordWidth-1:0] instructionWord(logic [opcodeWidth-1:0] op);
		logic [wordWidth-1:0] fields;
		fields = $random(seed); // register and immediate fields are arbitrary
		return {op, fields[opcodeLsb-1:0]};
	endfunction

	// new instruction word goes on ir at the end of fetch1
	always @(posedge clk) begin
		if (!Reset && readRam && enable[pcIn]) begin
			if (pending.size() > 0)
				nextOp = pending.pop_front();
			else
				nextOp = opNop;
			ir <= instructionWord(nextOp);
			coin = $random(seed);
			CONFFOut <= coin[0]; // branch condition for this instruction
		end
	end

	always @(negedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit)
			abortRun("timeout, run did not end within the cycle limit");
		else if (controlUnit_i.controlUnit_properties_i.failCount != 0)
			abortRun("an assertion on controlUnit failed");
	end

	initial begin
		Reset <= 1'b1;
		Stop <= 1'b0;
		repeat (5) @(posedge clk);
		Reset <= 1'b0;
		while (run)
			@(posedge clk); // program ends in halt
		repeat (3) @(posedge clk);

		// second run, stopped in the middle of ld
		Reset <= 1'b1;
		repeat (5) @(posedge clk);
		Reset <= 1'b0;
		repeat (12) @(posedge clk);
		Stop <= 1'b1;
		while (run)
			@(posedge clk);
		repeat (3) @(posedge clk); // halted has to hold
		@(negedge clk); // assertions of the last edge have reported

		if (controlUnit_i.controlUnit_properties_i.failCount != 0)
			abortRun("an assertion on controlUnit failed");
		else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
source/isaPkg.sv
source/datapathPkg.sv
source/opcodeDecoder.sv
source/stepSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
testbench/controlUnit_properties.sv
testbench/controlUnit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f tb.f --top-module controlUnit_tb -o controlUnit_sim

# keep going past the first assertion so the testbench reports the failure itself
out=$(./obj_dir/controlUnit_sim +verilator+error+limit+100 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
